//--- design/dekatronCounter.sv
`timescale 1ns/100ps
`default_nettype none

`include "dekatron_defines.svh"

module dekatronCounter #(
	parameter int numDigits = `DEKATRON_NUM,
	parameter bit topLimitMode = 1'b0,
	parameter logic [numDigits*`DEKATRON_WIDTH-1:0] topValue = `DEKATRON_TOP
) (
	input wire Rst_n,
	input wire Clk,
	input wire hsClk, // Tube timing clock, ten times Clk

	input wire Request,
	input wire Dec,
	input wire Set,
	input wire SetZero,
	input wire [numDigits*`DEKATRON_WIDTH-1:0] In,

	output logic Ready,
	output logic Zero,
	output wire [numDigits*`DEKATRON_WIDTH-1:0] Out
);
	import dekatronPkg::*;

	localparam int w = `DEKATRON_WIDTH;

	ctrlStateT state, stateNext;

	logic reqD, reqRise, reqEdge;
	logic decQ, setQ, setZeroQ;
	logic [numDigits*w-1:0] inQ;
	logic [numDigits*w-1:0] loadData;
	logic pulseF, pulseR, load;
	logic atTop;
	logic [numDigits-1:0] carryHighQ; // Carry levels as they stood before the step
	logic [numDigits-1:0] carryLowQ;

	wire [numDigits-1:0] zeroes;
	wire [numDigits-1:0] tops;
	wire [numDigits-1:0] busies;
	wire [numDigits-1:0] carryHighs;
	wire [numDigits-1:0] carryLows;
	wire [numDigits-1:0] fwdF; // Increment strobe per decade after carry gating
	wire [numDigits-1:0] fwdR;

	////////////////////////////////////////////////////////////////////////////
	// Request capture
	////////////////////////////////////////////////////////////////////////////

	assign reqRise = Request & ~reqD;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			reqD <= 1'b0;
			reqEdge <= 1'b0;
		end else begin
			reqD <= Request;
			reqEdge <= reqRise;
		end
	end

	// Qualifiers and data frozen on the edge
	always_ff @(posedge Clk) begin
		if (reqRise) begin
			decQ <= Dec;
			setQ <= Set;
			setZeroQ <= SetZero;
			inQ <= In;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Operation FSM
	////////////////////////////////////////////////////////////////////////////

	assign atTop = &tops;

	always_comb begin
		stateNext = stIdle;
		if (state == stIdle && reqEdge) begin
			if (setQ)
				stateNext = stSet;
			else if (setZeroQ)
				stateNext = stSetZero;
			else if (topLimitMode && decQ && Zero)
				stateNext = stSetTop; // Wrap below zero
			else if (topLimitMode && !decQ && atTop)
				stateNext = stSetZero; // Wrap past top
			else if (decQ)
				stateNext = stDec;
			else
				stateNext = stInc;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n)
			state <= stIdle;
		else
			state <= stateNext;
	end

	// Every non-idle state lasts one cycle, so these are one-cycle strobes
	assign pulseF = (state == stInc);
	assign pulseR = (state == stDec);
	assign load = state[2];

	always_comb begin
		case (state)
			stSetTop: loadData = topValue;
			stSetZero: loadData = '0;
			default: loadData = inQ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Decade array with carry rippling
	////////////////////////////////////////////////////////////////////////////

	// A decade reaching its boundary mid-pulse must not pass on a late strobe
	always_ff @(posedge Clk) begin
		if (state == stIdle) begin
			carryHighQ <= carryHighs;
			carryLowQ <= carryLows;
		end
	end

	dekatronDigitIf dig[numDigits] ();

	for (genvar d = 0; d < numDigits; d++) begin : gDecade
		if (d == 0) begin : gUnits
			assign fwdF[d] = pulseF;
			assign fwdR[d] = pulseR;
		end else begin : gHigher
			assign fwdF[d] = fwdF[d-1] & carryHighQ[d-1];
			assign fwdR[d] = fwdR[d-1] & carryLowQ[d-1];
		end

		assign dig[d].pulseF = fwdF[d];
		assign dig[d].pulseR = fwdR[d];
		assign dig[d].load = load;
		assign dig[d].din = loadData[d*w +: w];

		assign Out[d*w +: w] = dig[d].dout;
		assign zeroes[d] = dig[d].zero;
		assign tops[d] = dig[d].topPin;
		assign busies[d] = dig[d].busy;
		assign carryHighs[d] = dig[d].carryHigh;
		assign carryLows[d] = dig[d].carryLow;

		dekatronDecade #(
			.topDigit(topValue[d*w +: w])
		) u_dekatronDecade (
			.Rst_n(Rst_n),
			.hsClk(hsClk),
			.bus(dig[d])
		);
	end

	assign Zero = &zeroes;
	assign Ready = ~Request & ~reqEdge & (state == stIdle) & ~(|busies);

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	stateLegal: assert property (@(posedge Clk) disable iff (!Rst_n)
		state inside {stIdle, stInc, stDec, stSetZero, stSetTop, stSet})
		else $error("Controller state illegal");

	stepNotLoad: assert property (@(posedge Clk) disable iff (!Rst_n)
		(|fwdF || |fwdR) |-> !load)
		else $error("Step pulse overlaps a load");

endmodule

`default_nettype wire

//--- design/dekatronDecade.sv
`timescale 1ns/100ps
`default_nettype none

`include "dekatron_defines.svh"

module dekatronDecade #(
	parameter dekatronPkg::digitT topDigit = '0
) (
	input wire Rst_n,
	input wire hsClk,
	dekatronDigitIf.decade bus
);
	import dekatronPkg::*;

	localparam int delayMax = `DEKATRON_DELAY - 1;
	localparam int cntW = $clog2(`DEKATRON_DELAY + 1);

	logic [9:0] ring; // One-hot cathode position
	logic pulseFQ, pulseRQ, loadQ;
	logic edgeF, edgeR, edgeLoad, anyEdge;
	logic busy;
	logic opLoad, opDec;
	logic [cntW-1:0] delayCnt;
	digitT loadDigit;

	// Cathode for a digit, falls back to 0 on non-BCD input
	function automatic logic [9:0] digitToRing(input digitT d);
		logic [9:0] r;
		r = '0;
		if (d > digitT'(9))
			r[0] = 1'b1;
		else
			r[d] = 1'b1;
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Strobe edge detection in the hsClk domain
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			pulseFQ <= 1'b0;
			pulseRQ <= 1'b0;
			loadQ <= 1'b0;
		end else begin
			pulseFQ <= bus.pulseF;
			pulseRQ <= bus.pulseR;
			loadQ <= bus.load;
		end
	end

	assign edgeF = bus.pulseF & ~pulseFQ;
	assign edgeR = bus.pulseR & ~pulseRQ;
	assign edgeLoad = bus.load & ~loadQ;
	assign anyEdge = edgeF | edgeR | edgeLoad;

	////////////////////////////////////////////////////////////////////////////
	// Glow transfer with tube delay
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge hsClk or negedge Rst_n) begin
		if (!Rst_n) begin
			ring <= 10'd1;
			busy <= 1'b0;
			opLoad <= 1'b0;
			opDec <= 1'b0;
			delayCnt <= '0;
		end else if (!busy) begin
			if (anyEdge) begin
				busy <= 1'b1;
				opLoad <= edgeLoad; // Load wins over a step
				opDec <= edgeR & ~edgeF;
				delayCnt <= cntW'(delayMax);
			end
		end else if (delayCnt != '0) begin
			delayCnt <= delayCnt - 1'b1;
		end else begin
			busy <= 1'b0;
			if (opLoad)
				ring <= digitToRing(loadDigit);
			else if (opDec)
				ring <= {ring[0], ring[9:1]}; // Glow moves down
			else
				ring <= {ring[8:0], ring[9]}; // Glow moves up
		end
	end

	// Load value taken with the edge
	always_ff @(posedge hsClk) begin
		if (!busy && edgeLoad)
			loadDigit <= bus.din;
	end

	// Cathode index back to BCD
	always_comb begin
		bus.dout = '0;
		for (int i = 0; i < 10; i++) begin
			if (ring[i])
				bus.dout = digitT'(i);
		end
	end

	assign bus.zero = ring[0];
	assign bus.topPin = ring[topDigit];
	assign bus.carryHigh = ring[9];
	assign bus.carryLow = ring[0];
	assign bus.busy = busy;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	ringOneHot: assert property (@(posedge hsClk) disable iff (!Rst_n)
		$onehot(ring))
		else $error("Cathode ring lost its single glow");

	busyNeedsEdge: assert property (@(posedge hsClk) disable iff (!Rst_n)
		$rose(busy) |-> $past(anyEdge))
		else $error("Decade went busy without a strobe");

endmodule

`default_nettype wire

//--- design/dekatronDigitIf.sv
`timescale 1ns/100ps
`default_nettype none

interface dekatronDigitIf;
	import dekatronPkg::*;

	logic pulseF; // Increment strobe
	logic pulseR; // Decrement strobe
	logic load;   // Load level
	digitT din;

	digitT dout;
	logic zero;
	logic topPin;
	logic carryHigh; // Ring at cathode 9
	logic carryLow;  // Ring at cathode 0
	logic busy;

	modport ctrl (
		output pulseF, pulseR, load, din,
		input dout, zero, topPin, carryHigh, carryLow, busy
	);

	modport decade (
		input pulseF, pulseR, load, din,
		output dout, zero, topPin, carryHigh, carryLow, busy
	);

endinterface

`default_nettype wire

//--- design/dekatronPkg.sv
`default_nettype none

`include "dekatron_defines.svh"

package dekatronPkg;

	// One decimal digit as seen on a tube
	typedef logic [`DEKATRON_WIDTH-1:0] digitT;

	// Controller states, bit 2 marks a load into the decades
	typedef enum logic [2:0] {
		stIdle    = 3'b000,
		stInc     = 3'b010,
		stDec     = 3'b011,
		stSetZero = 3'b101,
		stSetTop  = 3'b110,
		stSet     = 3'b111
	} ctrlStateT;

endpackage

`default_nettype wire

//--- design/dekatronTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "dekatron_defines.svh"

module dekatronTop (
	input wire Clk,
	input wire hsClk,
	input wire Rst_n,

	input wire Request,
	input wire Dec,
	input wire Set,
	input wire SetZero,
	input wire [`DEKATRON_NUM*`DEKATRON_WIDTH-1:0] In,

	output wire Ready,
	output wire Zero,
	output wire [`DEKATRON_NUM*`DEKATRON_WIDTH-1:0] Out
);

	// Three decades wrapping between 000 and the top value
	dekatronCounter #(
		.numDigits(`DEKATRON_NUM),
		.topLimitMode(1'b1),
		.topValue(`DEKATRON_TOP)
	) u_dekatronCounter (
		.Rst_n(Rst_n),
		.Clk(Clk),
		.hsClk(hsClk),
		.Request(Request),
		.Dec(Dec),
		.Set(Set),
		.SetZero(SetZero),
		.In(In),
		.Ready(Ready),
		.Zero(Zero),
		.Out(Out)
	);

endmodule

`default_nettype wire

//--- include/dekatron_defines.svh
`ifndef DEKATRON_DEFINES_SVH
`define DEKATRON_DEFINES_SVH

// Bits per BCD digit
`define DEKATRON_WIDTH 4

// Decades in a counter
`define DEKATRON_NUM 3

// hsClk cycles per glow transfer or load, must stay below one Clk period
`define DEKATRON_DELAY 6

// Default top value for top-limit mode, BCD
`define DEKATRON_TOP 12'h555

`endif

//--- run_sim.sh
#!/bin/bash
# Build and run the dekatron counter testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module dekatronTb -Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- verification/dekatronTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dekatron_defines.svh"

module dekatronTb;

	localparam int outW = `DEKATRON_NUM * `DEKATRON_WIDTH;

	logic Clk, hsClk, Rst_n;
	logic Request, Dec, Set, SetZero;
	logic [outW-1:0] In;
	wire Ready, Zero;
	wire [outW-1:0] Out;

	string opQ[$];
	logic [outW-1:0] inQ[$];
	logic [outW-1:0] outQ[$];
	logic zeroQ[$];
	int errors, checks, cycles, limit;

	dekatronTop u_dekatronTop (
		.Clk(Clk), .hsClk(hsClk), .Rst_n(Rst_n),
		.Request(Request), .Dec(Dec), .Set(Set), .SetZero(SetZero), .In(In),
		.Ready(Ready), .Zero(Zero), .Out(Out)
	);

	always #20 Clk = ~Clk;
	always #2 hsClk = ~hsClk; // Rises with every Clk rise

	always @(posedge Clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: Ready did not return within %0d cycles", limit);
			$display("%0d checks, %0d errors", checks, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic checkValue(string name, logic [outW-1:0] exp, logic [outW-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	// Trace lines are: op in expectedOut expectedZero
	task automatic readTrace();
		int fd;
		int n;
		int zV;
		string line, op;
		logic [outW-1:0] inV, outV;
		fd = $fopen("verification/dekatron_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the trace file");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %d", op, inV, outV, zV);
				if (n == 4) begin
					opQ.push_back(op);
					inQ.push_back(inV);
					outQ.push_back(outV);
					zeroQ.push_back(zV != 0);
				end
			end
		end
		$fclose(fd);
		if (opQ.size() == 0) begin
			errors++;
			$display("Trace file holds no operations");
		end
	endtask

	// One request pulse, then wait for Ready
	task automatic runOp(string op, logic [outW-1:0] value);
		@(negedge Clk);
		if (op != "inc" && op != "dec" && op != "set" &&
			op != "clr" && op != "clrdec") begin
			errors++;
			$display("Unknown trace operation %s", op);
		end
		Dec = (op == "dec" || op == "clrdec");
		Set = (op == "set");
		SetZero = (op == "clr" || op == "clrdec"); // Clear beats Dec
		In = value;
		Request = 1'b1;
		@(negedge Clk);
		Request = 1'b0;
		Dec = 1'b0;
		Set = 1'b0;
		SetZero = 1'b0;
		@(negedge Clk);
		while (!Ready)
			@(negedge Clk);
	endtask

	initial begin
		Clk = 1'b0;
		hsClk = 1'b1;
		Rst_n = 1'b0;
		Request = 1'b0;
		Dec = 1'b0;
		Set = 1'b0;
		SetZero = 1'b0;
		In = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit = 0;
		readTrace();
		limit = 40 * opQ.size() + 50;

		repeat (5) @(negedge Clk);
		Rst_n = 1'b1;
		@(negedge Clk);
		checkValue("Out", '0, Out);
		checkValue("Zero", 1, Zero);
		checkValue("Ready", 1, Ready);

		foreach (opQ[i]) begin
			runOp(opQ[i], inQ[i]);
			checkValue("Out", outQ[i], Out);
			checkValue("Zero", zeroQ[i], Zero);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/dekatron_trace.txt
# op (inc dec set clr clrdec), In, expected Out, expected Zero
# In and Out are BCD in hex, top value is 555
set 123 123 0
set 000 000 1
set 555 555 0
set 099 099 0
inc 000 100 0
set 009 009 0
inc 000 010 0
dec 000 009 0
set 100 100 0
dec 000 099 0
set 001 001 0
dec 000 000 1
dec 000 555 0
inc 000 000 1
inc 000 001 0
set 347 347 0
clr 000 000 1
set 210 210 0
clrdec 000 000 1
set 554 554 0
inc 000 555 0
inc 000 000 1
dec 000 555 0
dec 000 554 0

//--- vlog.f
+incdir+include
design/dekatronPkg.sv
design/dekatronDigitIf.sv
design/dekatronDecade.sv
design/dekatronCounter.sv
design/dekatronTop.sv
verification/dekatronTb.sv
